// File: rtl/calc_pkg.sv
// Calculator front end shared definitions
// Widths, state encodings, error codes and configuration defaults

package calc_pkg;

    // ======================================================================
    // Data widths
    // ======================================================================
    typedef logic [7:0] byte_t;
    typedef logic [3:0] cfg_t;
    // Segment order g f e d c b a, active high
    typedef logic [6:0] seg_t;
    typedef logic [2:0] count_t;

    // ======================================================================
    // State and error encodings
    // ======================================================================
    // Mode values double as the digit on the mode display
    typedef enum logic [2:0] {
        main_menu    = 3'd0,
        mode_setting = 3'd5
    } main_state_t;

    typedef enum logic [1:0] {
        sub_idle,
        sub_wait_dim,
        sub_wait_value,
        sub_done
    } sub_state_t;

    typedef enum logic [1:0] {
        err_none      = 2'd0,
        err_not_digit = 2'd1,
        err_range     = 2'd2
    } error_code_t;

    // DIP code for setting mode
    localparam logic [2:0] dip_setting = 3'd5;
    localparam cfg_t max_dim_limit = 4'd5;
    localparam cfg_t default_max_dim = 4'd2;
    localparam cfg_t default_max_value = 4'd9;
    localparam count_t error_seconds = 3'd7;

endpackage

// File: rtl/calc_status_if.sv
// Status bus between the mode FSM, setting mode, error timer and display
// Carries mode, sub-state, error and countdown

`timescale 1ns/1ns

interface calc_status_if;

    calc_pkg::main_state_t main_state;
    calc_pkg::sub_state_t  sub_state;
    calc_pkg::error_code_t error_code;
    logic                  error_active;
    calc_pkg::count_t      countdown;

    modport mode_src (output main_state);

    modport setting_src (
        input  main_state,
        output sub_state,
        output error_code
    );

    modport timer_src (
        input  error_code,
        output error_active,
        output countdown
    );

    modport disp_sink (
        input main_state,
        input sub_state,
        input error_code,
        input error_active,
        input countdown
    );

endinterface

// File: rtl/button_debounce.sv
// Push button debouncer
// Synchronises the raw input and gives one pulse per accepted press

`timescale 1ns/1ns

module button_debounce #(
    parameter int debounce_cycles = 1000000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_in,
    output logic btn_pulse
);

    localparam int cnt_w = $clog2(debounce_cycles) + 1;

    logic [1:0]       sync_q;
    logic             stable_level;
    logic [cnt_w-1:0] stable_cnt;

    // Count consecutive cycles that differ from the accepted level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q       <= 2'b00;
            stable_level <= 1'b0;
            stable_cnt   <= '0;
            btn_pulse    <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], btn_in};
            btn_pulse <= 1'b0;
            if (sync_q[1] == stable_level) begin
                stable_cnt <= '0;
            end else if (stable_cnt == cnt_w'(debounce_cycles - 1)) begin
                stable_cnt   <= '0;
                stable_level <= sync_q[1];
                // Pulse on press only, release just rearms
                btn_pulse    <= sync_q[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        btn_pulse |=> !btn_pulse);

endmodule

// File: rtl/uart_rx.sv
// UART receiver, 8N1
// Samples each bit at its middle and strobes every good byte

`timescale 1ns/1ns

module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            uart_rx,
    output calc_pkg::byte_t rx_data,
    output logic            rx_done
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t       state;
    logic [2:0]      sync_q;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]      bit_idx;
    calc_pkg::byte_t shift_q;
    logic            rx_s;
    logic            bit_mid;
    logic            sample_en;

    assign rx_s    = sync_q[1];
    assign bit_mid = (clk_cnt == cnt_w'(clks_per_bit - 1));
    assign sample_en = (state == st_data) && bit_mid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q  <= 3'b111;
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            sync_q  <= {sync_q[1:0], uart_rx};
            rx_done <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    // Falling edge on the line
                    if (sync_q[2] && !rx_s) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // Recheck the start bit halfway through
                    if (clk_cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (bit_mid) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                default: begin
                    if (bit_mid) begin
                        rx_done <= rx_s;
                        state   <= st_idle;
                    end
                end
            endcase
        end
    end

    // Payload path, LSB first
    always_ff @(posedge clk) begin
        if (sample_en) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
        if (state == st_stop && bit_mid && rx_s) begin
            rx_data <= shift_q;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done);

endmodule

// File: rtl/mode_ctrl.sv
// Main menu FSM
// Dispatches on the DIP switches when confirm is pressed

`timescale 1ns/1ns

module mode_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  confirm_pulse,
    input  logic                  back_pulse,
    input  logic [2:0]            dip_sw,
    calc_status_if.mode_src       status
);

    calc_pkg::main_state_t state;
    calc_pkg::main_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            calc_pkg::main_menu: begin
                if (confirm_pulse && dip_sw == calc_pkg::dip_setting) begin
                    state_next = calc_pkg::mode_setting;
                end
            end
            default: begin
                if (back_pulse) begin
                    state_next = calc_pkg::main_menu;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= calc_pkg::main_menu;
        end else begin
            state <= state_next;
        end
    end

    assign status.main_state = state;

    a_legal_mode: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {calc_pkg::main_menu, calc_pkg::mode_setting});

endmodule

// File: rtl/setting_mode.sv
// Configuration setting mode
// Takes the max dimension and max value as ASCII digits from the UART
// and raises an error on bad input until the error timer releases it

`timescale 1ns/1ns

module setting_mode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  calc_pkg::byte_t      rx_data,
    input  logic                 rx_done,
    input  logic                 confirm_pulse,
    input  logic                 timeout,
    calc_status_if.setting_src   status,
    output calc_pkg::cfg_t       config_max_dim,
    output calc_pkg::cfg_t       config_max_value
);

    calc_pkg::sub_state_t  sub_q;
    calc_pkg::error_code_t err_q;
    calc_pkg::cfg_t        max_dim_q;
    calc_pkg::cfg_t        max_value_q;
    logic                  active;
    logic                  is_digit;
    calc_pkg::cfg_t        digit;
    logic                  dim_ok;

    assign active   = (status.main_state == calc_pkg::mode_setting);
    // ASCII '0' to '9'
    assign is_digit = (rx_data >= 8'h30) && (rx_data <= 8'h39);
    assign digit    = calc_pkg::cfg_t'(rx_data[3:0]);
    assign dim_ok   = (digit != 4'd0) && (digit <= calc_pkg::max_dim_limit);

    // ======================================================================
    // Digit parser
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sub_q       <= calc_pkg::sub_idle;
            err_q       <= calc_pkg::err_none;
            max_dim_q   <= calc_pkg::default_max_dim;
            max_value_q <= calc_pkg::default_max_value;
        end else if (!active) begin
            sub_q <= calc_pkg::sub_idle;
            err_q <= calc_pkg::err_none;
        end else if (err_q != calc_pkg::err_none) begin
            // Bytes dropped while the error is shown
            if (timeout) begin
                err_q <= calc_pkg::err_none;
            end
        end else if (sub_q == calc_pkg::sub_idle) begin
            sub_q <= calc_pkg::sub_wait_dim;
        end else if (rx_done) begin
            if (!is_digit) begin
                err_q <= calc_pkg::err_not_digit;
            end else if (sub_q == calc_pkg::sub_wait_dim) begin
                if (dim_ok) begin
                    max_dim_q <= digit;
                    sub_q     <= calc_pkg::sub_wait_value;
                end else begin
                    err_q <= calc_pkg::err_range;
                end
            end else if (sub_q == calc_pkg::sub_wait_value) begin
                max_value_q <= digit;
                sub_q       <= calc_pkg::sub_done;
            end
        end else if (confirm_pulse && sub_q == calc_pkg::sub_done) begin
            // Start over for a new pair
            sub_q <= calc_pkg::sub_wait_dim;
        end
    end

    assign status.sub_state  = sub_q;
    assign status.error_code = err_q;
    assign config_max_dim    = max_dim_q;
    assign config_max_value  = max_value_q;

endmodule

// File: rtl/error_timer.sv
// Error timer
// Counts down the error display in ticks and pulses timeout at the end

`timescale 1ns/1ns

module error_timer #(
    parameter int tick_cycles = 100000000
) (
    input  logic              clk,
    input  logic              rst_n,
    calc_status_if.timer_src  status,
    output logic              timeout
);

    localparam int tick_w = $clog2(tick_cycles) + 1;

    logic              active_q;
    logic [tick_w-1:0] tick_cnt;
    calc_pkg::count_t  seconds_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q  <= 1'b0;
            tick_cnt  <= '0;
            seconds_q <= calc_pkg::error_seconds;
            timeout   <= 1'b0;
        end else begin
            timeout <= 1'b0;
            if (status.error_code == calc_pkg::err_none || timeout) begin
                // Idle, or waiting for the error to be released
                active_q  <= 1'b0;
                tick_cnt  <= '0;
                seconds_q <= calc_pkg::error_seconds;
            end else if (!active_q) begin
                active_q  <= 1'b1;
                tick_cnt  <= '0;
                seconds_q <= calc_pkg::error_seconds;
            end else if (tick_cnt == tick_w'(tick_cycles - 1)) begin
                tick_cnt <= '0;
                if (seconds_q == 3'd1) begin
                    // Last second done, show 0 with the timeout
                    seconds_q <= '0;
                    active_q  <= 1'b0;
                    timeout   <= 1'b1;
                end else begin
                    seconds_q <= seconds_q - 1'b1;
                end
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign status.error_active = active_q;
    assign status.countdown    = seconds_q;

    // Timeout only releases an error that is still raised
    a_timeout_with_error: assert property (@(posedge clk) disable iff (!rst_n)
        timeout |-> status.error_code != calc_pkg::err_none);

endmodule

// File: rtl/status_display.sv
// Status display
// Seven-segment digits for mode, error and countdown, plus status LEDs

`timescale 1ns/1ns

module status_display (
    calc_status_if.disp_sink status,
    output calc_pkg::seg_t   seg_display,
    output calc_pkg::seg_t   seg_countdown,
    output logic [3:0]       led_status
);

    // Digit to segments, g f e d c b a
    function automatic calc_pkg::seg_t seg_encode(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h40;
        endcase
    endfunction

    logic [3:0] main_digit;

    // Mode encoding is the digit itself
    assign main_digit = status.error_active ? {2'b00, status.error_code}
                                            : {1'b0, status.main_state};

    assign seg_display   = seg_encode(main_digit);
    assign seg_countdown = seg_encode({1'b0, status.countdown});

    assign led_status = {status.error_active,
                         status.sub_state == calc_pkg::sub_done,
                         status.main_state == calc_pkg::mode_setting,
                         status.main_state == calc_pkg::main_menu};

endmodule

// File: rtl/calc_top.sv
// Calculator front end top level
// Buttons, menu FSM, UART setting mode, error timer and status display

`timescale 1ns/1ns

module calc_top #(
    parameter int clks_per_bit    = 868,
    parameter int debounce_cycles = 1000000,
    parameter int tick_cycles     = 100000000
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [2:0]     dip_sw,
    input  logic           btn_confirm,
    input  logic           btn_back,
    input  logic           uart_rx,
    output calc_pkg::seg_t seg_display,
    output calc_pkg::seg_t seg_countdown,
    output logic [3:0]     led_status,
    output calc_pkg::cfg_t config_max_dim,
    output calc_pkg::cfg_t config_max_value
);

    logic            confirm_pulse;
    logic            back_pulse;
    calc_pkg::byte_t rx_data;
    logic            rx_done;
    logic            timeout;

    calc_status_if status_bus ();

    // ======================================================================
    // Inputs
    // ======================================================================
    button_debounce #(.debounce_cycles(debounce_cycles)) db_confirm (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_confirm),
        .btn_pulse (confirm_pulse)
    );

    button_debounce #(.debounce_cycles(debounce_cycles)) db_back (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_back),
        .btn_pulse (back_pulse)
    );

    uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_rx),
        .rx_data (rx_data),
        .rx_done (rx_done)
    );

    // ======================================================================
    // Control and status
    // ======================================================================
    mode_ctrl u_mode_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .confirm_pulse (confirm_pulse),
        .back_pulse    (back_pulse),
        .dip_sw        (dip_sw),
        .status        (status_bus.mode_src)
    );

    setting_mode u_setting_mode (
        .clk              (clk),
        .rst_n            (rst_n),
        .rx_data          (rx_data),
        .rx_done          (rx_done),
        .confirm_pulse    (confirm_pulse),
        .timeout          (timeout),
        .status           (status_bus.setting_src),
        .config_max_dim   (config_max_dim),
        .config_max_value (config_max_value)
    );

    error_timer #(.tick_cycles(tick_cycles)) u_error_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .status  (status_bus.timer_src),
        .timeout (timeout)
    );

    status_display u_status_display (
        .status        (status_bus.disp_sink),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status)
    );

endmodule

// File: testbench/tb_calc_top.sv
// Testbench for the calculator front end
// Plays a golden command script through the buttons and the UART line
// and checks LEDs, seven-segment digits and configuration ports

`timescale 1ns/1ns

module tb_calc_top;

    localparam int    bit_cycles  = 8;
    localparam int    tick_len    = 40;
    localparam int    err_secs    = 7;
    localparam int    press_hold  = 12;
    localparam int    press_gap   = 12;
    localparam int    byte_gap    = 4;
    localparam string script_path = "testbench/calc_golden.txt";

    logic           clk;
    logic           rst_n;
    logic [2:0]     dip_sw;
    logic           btn_confirm;
    logic           btn_back;
    logic           uart_line;
    calc_pkg::seg_t seg_display;
    calc_pkg::seg_t seg_countdown;
    logic [3:0]     led_status;
    calc_pkg::cfg_t config_max_dim;
    calc_pkg::cfg_t config_max_value;

    int     cycle = 0;
    int     cycle_limit = 0;
    int     rise_cycle = -1;
    int     consumed_rise = -1;
    logic   err_led_q = 1'b0;
    int     error_count = 0;
    int     check_count = 0;
    integer seed = 65;
    int     exp_dim = 0;
    int     exp_value = 0;

    calc_top #(
        .clks_per_bit    (bit_cycles),
        .debounce_cycles (4),
        .tick_cycles     (tick_len)
    ) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .dip_sw           (dip_sw),
        .btn_confirm      (btn_confirm),
        .btn_back         (btn_back),
        .uart_rx          (uart_line),
        .seg_display      (seg_display),
        .seg_countdown    (seg_countdown),
        .led_status       (led_status),
        .config_max_dim   (config_max_dim),
        .config_max_value (config_max_value)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Cycle counter and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("Run stopped: script not finished after %0d cycles", cycle);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("Verification failed");
            $finish;
        end
    end

    // Remember the cycle in which the error LED came on
    always @(negedge clk) begin
        err_led_q <= led_status[3];
        if (led_status[3] && !err_led_q) begin
            rise_cycle <= cycle;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    // Segments g f e d c b a to a digit, -1 if not a digit
    function automatic int decode_segments(input calc_pkg::seg_t seg);
        case (seg)
            7'b0111111: return 0;
            7'b0000110: return 1;
            7'b1011011: return 2;
            7'b1001111: return 3;
            7'b1100110: return 4;
            7'b1101101: return 5;
            7'b1111101: return 6;
            7'b0000111: return 7;
            7'b1111111: return 8;
            7'b1101111: return 9;
            default:    return -1;
        endcase
    endfunction

    // Worst-case cycles of one script command
    function automatic int command_cost(input string cmd);
        if (cmd == "press") begin
            return 1 + press_hold + press_gap;
        end else if (cmd == "send" || cmd == "rand") begin
            return 10 * bit_cycles + byte_gap + 2;
        end else if (cmd == "expect") begin
            return 1;
        end else if (cmd == "expect_error") begin
            return err_secs * tick_len + 2;
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        assert (actual == expected)
        else begin
            error_count++;
            $display("** Error at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Check failed at %0t ns: %s", $time, msg);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic press_button(input string which, input logic [2:0] dip);
        @(posedge clk);
        dip_sw <= dip;
        if (which == "confirm") begin
            btn_confirm <= 1'b1;
        end else if (which == "back") begin
            btn_back <= 1'b1;
        end else begin
            report_failure({"unknown button name ", which});
        end
        wait_cycles(press_hold);
        btn_confirm <= 1'b0;
        btn_back    <= 1'b0;
        wait_cycles(press_gap);
    endtask

    // 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_line <= frame[i];
            wait_cycles(bit_cycles - 1);
        end
        wait_cycles(1 + byte_gap);
    endtask

    task automatic send_random_non_digit();
        int         rnd;
        logic [7:0] data;
        rnd  = $random(seed);
        data = rnd[7:0];
        // Move a digit out of the ASCII digit range
        if (data >= 8'h30 && data <= 8'h39) begin
            data = data | 8'h40;
        end
        send_byte(data);
    endtask

    task automatic expect_status(input int led, input int dim, input int value);
        exp_dim   = dim;
        exp_value = value;
        @(negedge clk);
        check_value("led_status", led, int'(led_status));
        check_value("config_max_dim", dim, int'(config_max_dim));
        check_value("config_max_value", value, int'(config_max_value));
        // Menu shows 0, setting mode shows 5
        check_value("seg_display", led[1] ? 5 : 0, decode_segments(seg_display));
        check_value("seg_countdown", err_secs, decode_segments(seg_countdown));
    endtask

    task automatic expect_error_period(input int code);
        int n;
        @(negedge clk);
        if (!led_status[3] || rise_cycle < 0 || rise_cycle == consumed_rise) begin
            report_failure("error LED is not on where an error was expected");
        end else begin
            check_value("seg_display", code, decode_segments(seg_display));
            check_value("config_max_dim", exp_dim, int'(config_max_dim));
            check_value("config_max_value", exp_value, int'(config_max_value));
            n = cycle - rise_cycle;
            // Each countdown digit lasts one tick
            while (n < err_secs * tick_len) begin
                check_value("led_status[3]", 1, int'(led_status[3]));
                check_value("seg_countdown", err_secs - n / tick_len,
                            decode_segments(seg_countdown));
                @(negedge clk);
                n = cycle - rise_cycle;
            end
            check_value("led_status[3]", 0, int'(led_status[3]));
            check_value("seg_countdown", 0, decode_segments(seg_countdown));
            consumed_rise = rise_cycle;
        end
    endtask

    // ======================================================================
    // Script player
    // ======================================================================
    initial begin
        int    fd;
        string line;
        string cmd;
        string word;
        int    arg_a;
        int    arg_b;
        int    arg_c;
        int    n_fields;
        int    budget;

        rst_n       <= 1'b0;
        dip_sw      <= 3'd0;
        btn_confirm <= 1'b0;
        btn_back    <= 1'b0;
        uart_line   <= 1'b1;

        // First pass sizes the watchdog
        budget = 16 + 100;
        fd = $fopen(script_path, "r");
        if (fd == 0) begin
            report_failure("cannot open the golden script");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n_fields = $sscanf(line, "%s", cmd);
                if (n_fields == 1) begin
                    budget += command_cost(cmd);
                end
            end
            $fclose(fd);
        end
        cycle_limit = budget;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen(script_path, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                n_fields = $sscanf(line, "%s", cmd);
                if (n_fields == 1 && cmd.getc(0) != "#") begin
                    if (cmd == "press") begin
                        n_fields = $sscanf(line, "%s %s %h", cmd, word, arg_a);
                        press_button(word, arg_a[2:0]);
                    end else if (cmd == "send") begin
                        n_fields = $sscanf(line, "%s %h", cmd, arg_a);
                        send_byte(arg_a[7:0]);
                    end else if (cmd == "rand") begin
                        send_random_non_digit();
                    end else if (cmd == "expect") begin
                        n_fields = $sscanf(line, "%s %h %h %h", cmd, arg_a, arg_b, arg_c);
                        expect_status(arg_a, arg_b, arg_c);
                    end else if (cmd == "expect_error") begin
                        n_fields = $sscanf(line, "%s %h", cmd, arg_a);
                        expect_error_period(arg_a);
                    end else begin
                        report_failure({"unknown script command ", cmd});
                    end
                end
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sim.f
rtl/calc_pkg.sv
rtl/calc_status_if.sv
rtl/button_debounce.sv
rtl/uart_rx.sv
rtl/mode_ctrl.sv
rtl/setting_mode.sv
rtl/error_timer.sv
rtl/status_display.sv
rtl/calc_top.sv
testbench/tb_calc_top.sv

// File: Makefile
# Verilator lint, simulation and clean for the calculator front end

TOP = tb_calc_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module calc_top

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/calc_golden.txt
# Commands with numbers in hex: press <confirm|back> <dip>, send <byte>, rand,
# expect <led> <max_dim> <max_value>, expect_error <code>
expect 1 2 9
press confirm 3
expect 1 2 9
send 37
expect 1 2 9
press confirm 5
expect 2 2 9
send 34
expect 2 4 9
send 37
expect 6 4 7
press confirm 5
expect 2 4 7
send 38
expect_error 2
expect 2 4 7
rand
send 33
expect_error 1
expect 2 4 7
send 31
send 36
expect 6 1 6
press back 0
expect 1 1 6
